/* verilog/div_types_pkg.sv */
// Arithmetic definitions shared by the divide unit and its testbench
package div_types_pkg;

	// Operand and result width of the RV32 integer datapath
	localparam int XLEN = 32;

	// Divide opcodes in the same encoding as the pipeline's funct3 low bits
	// Bit 0 set means the operands are unsigned
	// Bit 1 set means the remainder is returned instead of the quotient
	typedef enum logic [1:0] {
		DIV  = 2'd0,
		DIVU = 2'd1,
		REM  = 2'd2,
		REMU = 2'd3
	} div_op_e;

	// Operand classes for which RISC-V defines a fixed result
	// The divider core still runs for these, but its result is replaced
	typedef enum logic [1:0] {
		// Ordinary division, the core result is used
		SPEC_NONE     = 2'd0,
		// Divisor is zero, for signed and unsigned ops alike
		// Quotient becomes all ones and the remainder becomes the dividend
		SPEC_DIV_ZERO = 2'd1,
		// Signed op with the most negative dividend and a divisor of minus one
		// Quotient becomes the dividend and the remainder becomes zero
		SPEC_OVERFLOW = 2'd2
	} special_e;

endpackage

/* verilog/div_bus_pkg.sv */
// Transport structures between the pipeline, the divide unit and its stages
package div_bus_pkg;

	// Request from the execute stage, transferred on a valid/ready handshake
	typedef struct packed {
		div_types_pkg::div_op_e         op;
		logic [div_types_pkg::XLEN-1:0] dividend;
		logic [div_types_pkg::XLEN-1:0] divisor;
	} div_req_t;

	// Response back to the pipeline, held stable under back-pressure
	typedef struct packed {
		logic [div_types_pkg::XLEN-1:0] result;
		// Set only when the divisor was zero
		logic                           div_by_zero;
	} div_rsp_t;

	// Registered output of operand preparation
	// The magnitudes feed the core, the remaining fields feed result fix-up
	typedef struct packed {
		logic [div_types_pkg::XLEN-1:0] abs_dividend;
		logic [div_types_pkg::XLEN-1:0] abs_divisor;
		div_types_pkg::div_op_e         op;
		logic                           neg_quot;
		logic                           neg_rem;
		div_types_pkg::special_e        spec;
		// Original dividend, needed for the divide-by-zero and overflow results
		logic [div_types_pkg::XLEN-1:0] dividend;
	} div_prep_t;

	// Unsigned results of the iterative core
	typedef struct packed {
		logic [div_types_pkg::XLEN-1:0] quotient;
		logic [div_types_pkg::XLEN-1:0] remainder;
	} core_out_t;

endpackage

/* verilog/div_operand_prep.sv */
`timescale 1ns/1ps
module div_operand_prep (
	input  logic                   CLK,
	input  logic                   nrst,
	input  logic                   prep_load,
	input  div_bus_pkg::div_req_t  req,
	output div_bus_pkg::div_prep_t prep
);
	localparam int XLEN = div_types_pkg::XLEN;

	// Most negative signed value, the only dividend that can overflow
	localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

	logic                   is_signed;
	logic                   dividend_neg;
	logic                   divisor_neg;
	div_bus_pkg::div_prep_t prep_next;

	// Bit 0 of the opcode marks the unsigned variants
	assign is_signed    = ~req.op[0];
	assign dividend_neg = is_signed & req.dividend[XLEN-1];
	assign divisor_neg  = is_signed & req.divisor[XLEN-1];

	always_comb begin
		prep_next.op       = req.op;
		prep_next.dividend = req.dividend;

		// Signs are stripped here so one unsigned core serves every opcode
		// The most negative value maps onto itself, which is the right magnitude
		prep_next.abs_dividend = dividend_neg ? (~req.dividend + 1'b1) : req.dividend;
		prep_next.abs_divisor  = divisor_neg ? (~req.divisor + 1'b1) : req.divisor;

		// Truncating division, the quotient is negative when the signs differ
		prep_next.neg_quot = dividend_neg ^ divisor_neg;
		// The remainder always carries the sign of the dividend
		prep_next.neg_rem  = dividend_neg;

		// Divide-by-zero takes precedence, it applies to unsigned ops too
		if (req.divisor == '0) begin
			prep_next.spec = div_types_pkg::SPEC_DIV_ZERO;
		end else if (is_signed && (req.dividend == MOST_NEG) && (req.divisor == '1)) begin
			prep_next.spec = div_types_pkg::SPEC_OVERFLOW;
		end else begin
			prep_next.spec = div_types_pkg::SPEC_NONE;
		end
	end

	// The request may change after the accepting edge, so it is captured here
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			prep <= '0;
		end else if (prep_load) begin
			prep <= prep_next;
		end
	end

endmodule

/* verilog/div_radix2_core.sv */
`timescale 1ns/1ps
module div_radix2_core #(
	parameter int BITS_PER_CYCLE = 4
) (
	input  logic                             CLK,
	input  logic                             nrst,
	input  logic                             core_start,
	input  logic [div_types_pkg::XLEN-1:0]   abs_dividend,
	input  logic [div_types_pkg::XLEN-1:0]   abs_divisor,
	output logic                             core_done,
	output div_bus_pkg::core_out_t           core_out
);
	localparam int XLEN  = div_types_pkg::XLEN;
	// Number of clock edges spent iterating on one division
	localparam int STEPS = XLEN / BITS_PER_CYCLE;
	localparam int CNT_W = $clog2(STEPS + 1);

	if (!(BITS_PER_CYCLE inside {1, 2, 4, 8})) begin : g_bad_bits_per_cycle
		$error("BITS_PER_CYCLE must be 1, 2, 4 or 8");
	end

	logic             running;
	logic [CNT_W-1:0] step_cnt;
	// Partial remainder
	logic [XLEN-1:0]  rem_q;
	// Dividend shifts out at the top while quotient bits shift in at the bottom
	logic [XLEN-1:0]  dvd_q;
	logic [XLEN-1:0]  dsr_q;
	logic [XLEN-1:0]  rem_step;
	logic [XLEN-1:0]  dvd_step;

	// Unrolled compare-subtract chain with one stage per quotient bit
	always_comb begin
		logic [XLEN:0] shifted;
		logic [XLEN:0] diff;
		rem_step = rem_q;
		dvd_step = dvd_q;
		for (int i = 0; i < BITS_PER_CYCLE; i++) begin
			// Bring down the next dividend bit into the partial remainder
			shifted = {rem_step, dvd_step[XLEN-1]};
			diff    = shifted - {1'b0, dsr_q};
			// When the borrow bit is clear the divisor fit and the quotient bit is one
			dvd_step = {dvd_step[XLEN-2:0], ~diff[XLEN]};
			if (!diff[XLEN]) begin
				rem_step = diff[XLEN-1:0];
			end else begin
				// Restoring step keeps the shifted value unchanged
				rem_step = shifted[XLEN-1:0];
			end
		end
	end

	// Step counter and done pulse
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			running   <= 1'b0;
			step_cnt  <= '0;
			core_done <= 1'b0;
		end else begin
			core_done <= 1'b0;
			if (core_start) begin
				running  <= 1'b1;
				step_cnt <= CNT_W'(STEPS);
			end else if (running) begin
				step_cnt <= step_cnt - 1'b1;
				// Done is raised in the cycle after the last iterating edge
				if (step_cnt == CNT_W'(1)) begin
					running   <= 1'b0;
					core_done <= 1'b1;
				end
			end
		end
	end

	// Datapath registers hold their value after the last step until the next start
	always_ff @(posedge CLK) begin
		if (core_start) begin
			rem_q <= '0;
			dvd_q <= abs_dividend;
			dsr_q <= abs_divisor;
		end else if (running) begin
			rem_q <= rem_step;
			dvd_q <= dvd_step;
		end
	end

	// A zero divisor gives all ones and the dividend here and fix-up overrides both
	assign core_out.quotient  = dvd_q;
	assign core_out.remainder = rem_q;

	// The controller must wait for done before starting another division
	a_no_start_while_running: assert property (@(posedge CLK) disable iff (!nrst)
		core_start |-> !running);

endmodule

/* verilog/div_result_fix.sv */
`timescale 1ns/1ps
module div_result_fix (
	input  logic                   CLK,
	input  logic                   nrst,
	input  logic                   fix_load,
	input  div_bus_pkg::div_prep_t prep,
	input  div_bus_pkg::core_out_t core_out,
	output div_bus_pkg::div_rsp_t  rsp
);
	localparam int XLEN = div_types_pkg::XLEN;

	logic                  want_rem;
	logic                  negate;
	logic [XLEN-1:0]       magnitude;
	logic [XLEN-1:0]       signed_result;
	div_bus_pkg::div_rsp_t rsp_next;

	// Bit 1 of the opcode selects REM and REMU
	assign want_rem  = prep.op[1];
	assign magnitude = want_rem ? core_out.remainder : core_out.quotient;
	assign negate    = want_rem ? prep.neg_rem : prep.neg_quot;

	// Sign is put back on the unsigned core result
	assign signed_result = negate ? (~magnitude + 1'b1) : magnitude;

	always_comb begin
		rsp_next.result      = signed_result;
		rsp_next.div_by_zero = 1'b0;
		case (prep.spec)
			div_types_pkg::SPEC_DIV_ZERO: begin
				// Quotient of all ones, remainder equal to the dividend
				rsp_next.result      = want_rem ? prep.dividend : '1;
				rsp_next.div_by_zero = 1'b1;
			end
			div_types_pkg::SPEC_OVERFLOW: begin
				// Quotient wraps to the dividend, remainder is zero
				rsp_next.result = want_rem ? '0 : prep.dividend;
			end
			default: begin
				rsp_next.result = signed_result;
			end
		endcase
	end

	// The response register stays unchanged until the next fix_load
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			rsp <= '0;
		end else if (fix_load) begin
			rsp <= rsp_next;
		end
	end

endmodule

/* verilog/div_unit_ctrl.sv */
`timescale 1ns/1ps
module div_unit_ctrl (
	input  logic CLK,
	input  logic nrst,
	input  logic req_valid,
	output logic req_ready,
	input  logic rsp_ready,
	output logic rsp_valid,
	output logic busy,
	input  logic core_done,
	output logic prep_load,
	output logic core_start,
	output logic fix_load
);
	// IDLE waits for a request
	// START kicks the core with the registered operands
	// DIVIDING waits for the core to finish
	// FIX registers the signed and corrected result
	// RESP presents the result until the pipeline takes it
	typedef enum logic [2:0] {
		IDLE     = 3'd0,
		START    = 3'd1,
		DIVIDING = 3'd2,
		FIX      = 3'd3,
		RESP     = 3'd4
	} state_e;

	state_e state;
	state_e state_next;
	logic   accept;

	// Only one division is in flight, so requests are taken in IDLE alone
	assign req_ready = (state == IDLE);
	assign accept    = req_ready & req_valid;

	assign prep_load  = accept;
	assign core_start = (state == START);
	assign fix_load   = (state == FIX);
	assign rsp_valid  = (state == RESP);

	// The stall is raised already in the accepting cycle so the pipeline
	// freezes on the same edge that hands the operands over
	assign busy = accept | (state != IDLE);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (req_valid) begin
					state_next = START;
				end
			end
			START: begin
				state_next = DIVIDING;
			end
			DIVIDING: begin
				if (core_done) begin
					state_next = FIX;
				end
			end
			FIX: begin
				state_next = RESP;
			end
			RESP: begin
				// Back-pressure keeps the response and blocks new requests
				if (rsp_ready) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// The core may only report completion while the controller waits for it
	a_done_while_dividing: assert property (@(posedge CLK) disable iff (!nrst)
		core_done |-> (state == DIVIDING));

endmodule

/* verilog/div_subsystem.sv */
`timescale 1ns/1ps
module div_subsystem #(
	// Quotient bits retired per clock, latency is XLEN / BITS_PER_CYCLE + 3
	parameter int BITS_PER_CYCLE = 4
) (
	input  logic                  CLK,
	input  logic                  nrst,
	input  logic                  req_valid,
	input  div_bus_pkg::div_req_t req,
	output logic                  req_ready,
	output logic                  rsp_valid,
	output div_bus_pkg::div_rsp_t rsp,
	input  logic                  rsp_ready,
	output logic                  busy
);
	logic                   prep_load;
	logic                   core_start;
	logic                   core_done;
	logic                   fix_load;
	div_bus_pkg::div_prep_t prep;
	div_bus_pkg::core_out_t core_out;

	div_unit_ctrl u_ctrl (
		.CLK        (CLK),
		.nrst       (nrst),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.rsp_ready  (rsp_ready),
		.rsp_valid  (rsp_valid),
		.busy       (busy),
		.core_done  (core_done),
		.prep_load  (prep_load),
		.core_start (core_start),
		.fix_load   (fix_load)
	);

	div_operand_prep u_prep (
		.CLK       (CLK),
		.nrst      (nrst),
		.prep_load (prep_load),
		.req       (req),
		.prep      (prep)
	);

	// Core sees only magnitudes, the sign information bypasses it to the fix stage
	div_radix2_core #(
		.BITS_PER_CYCLE (BITS_PER_CYCLE)
	) u_core (
		.CLK          (CLK),
		.nrst         (nrst),
		.core_start   (core_start),
		.abs_dividend (prep.abs_dividend),
		.abs_divisor  (prep.abs_divisor),
		.core_done    (core_done),
		.core_out     (core_out)
	);

	div_result_fix u_fix (
		.CLK      (CLK),
		.nrst     (nrst),
		.fix_load (fix_load),
		.prep     (prep),
		.core_out (core_out),
		.rsp      (rsp)
	);

endmodule

/* testbench/tb_div_model.svh */
`ifndef TB_DIV_MODEL_SVH
`define TB_DIV_MODEL_SVH

// One step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Expected response following the RISC-V M extension rules
function automatic div_bus_pkg::div_rsp_t model_div(input div_bus_pkg::div_req_t r);
	div_bus_pkg::div_rsp_t  m;
	logic signed [XLEN-1:0] sa;
	logic signed [XLEN-1:0] sb;
	logic [XLEN-1:0]        q;
	logic [XLEN-1:0]        rem;
	logic                   is_unsigned;
	logic                   want_rem;
	sa          = r.dividend;
	sb          = r.divisor;
	is_unsigned = (r.op == div_types_pkg::DIVU) || (r.op == div_types_pkg::REMU);
	want_rem    = (r.op == div_types_pkg::REM) || (r.op == div_types_pkg::REMU);
	m.div_by_zero = 1'b0;
	if (r.divisor == '0) begin
		// Zero divisor gives all ones and hands the dividend back as remainder
		q             = '1;
		rem           = r.dividend;
		m.div_by_zero = 1'b1;
	end else if (!is_unsigned && (r.dividend == 32'h8000_0000) && (r.divisor == '1)) begin
		q   = r.dividend;
		rem = '0;
	end else if (is_unsigned) begin
		q   = r.dividend / r.divisor;
		rem = r.dividend % r.divisor;
	end else begin
		// Signed division truncates toward zero and the remainder follows the dividend
		q   = sa / sb;
		rem = sa % sb;
	end
	m.result = want_rem ? rem : q;
	return m;
endfunction

task automatic check_rsp(input string name, input div_bus_pkg::div_rsp_t exp,
		input div_bus_pkg::div_rsp_t act);
	if (exp !== act) begin
		$display("Error at %0t ns: %s expected %h (div_by_zero %b), actual %h (div_by_zero %b)",
			$time, name, exp.result, exp.div_by_zero, act.result, act.div_by_zero);
		stop_on_error();
	end
endtask

task automatic check_latency(input string name, input int exp, input int act);
	if (exp != act) begin
		$display("Error at %0t ns: %s expected %0d, actual %0d", $time, name, exp, act);
		stop_on_error();
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (exp !== act) begin
		$display("Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
		stop_on_error();
	end
endtask

`endif

/* testbench/tb_div_subsystem.sv */
`timescale 1ns/1ps
module tb_div_subsystem;
	localparam int XLEN              = div_types_pkg::XLEN;
	localparam int BITS_PER_CYCLE    = 4;
	// Edges from the accepting edge to the rise of rsp_valid
	localparam int LATENCY           = XLEN / BITS_PER_CYCLE + 3;
	localparam int NUM_OPS           = 2000;
	localparam int ACCEPT_TIMEOUT    = 50;
	localparam int RSP_TIMEOUT       = 4 * LATENCY;
	localparam int HANDSHAKE_TIMEOUT = 200;

	logic                  CLK;
	logic                  nrst;
	logic                  req_valid;
	div_bus_pkg::div_req_t req;
	logic                  req_ready;
	logic                  rsp_valid;
	div_bus_pkg::div_rsp_t rsp;
	logic                  rsp_ready;
	logic                  busy;

	logic [31:0]           rng_state;
	// Expected responses of accepted requests, oldest first
	div_bus_pkg::div_rsp_t exp_q[$];
	// Response handshakes seen on the bus
	int                    rsp_count = 0;

	`include "tb_div_model.svh"

	div_subsystem #(
		.BITS_PER_CYCLE (BITS_PER_CYCLE)
	) dut (
		.CLK       (CLK),
		.nrst      (nrst),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.rsp_ready (rsp_ready),
		.busy      (busy)
	);

	always begin
		#2 CLK = ~CLK;
	end

	// Every completed response handshake is counted to catch lost or repeated responses
	always @(posedge CLK) begin
		if (nrst && rsp_valid && rsp_ready) begin
			rsp_count <= rsp_count + 1;
		end
	end

	task automatic stop_on_error();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first failing check");
	endtask

	task automatic timeout_failure(input string what);
		$display("Timeout at %0t ns: gave up waiting for %s", $time, what);
		stop_on_error();
	endtask

	function automatic logic [31:0] draw_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Corner values come up often, so overflow and zero cases are hit many times
	function automatic logic [XLEN-1:0] pick_operand();
		logic [31:0] sel;
		logic [31:0] val;
		sel = draw_rand();
		val = draw_rand();
		case (sel[2:0])
			3'd0: return '0;
			3'd1: return '1;
			3'd2: return 32'h8000_0000;
			3'd3: return {28'd0, val[3:0]};
			3'd4: return -{28'd0, val[3:0]};
			default: return val;
		endcase
	endfunction

	// New random values go out on every rising edge and req changes even when ignored
	task automatic drive_random_inputs(input int valid_pct, input int ready_pct);
		div_bus_pkg::div_req_t r;
		logic [31:0]           op_bits;
		op_bits    = draw_rand();
		r.op       = div_types_pkg::div_op_e'(op_bits[1:0]);
		r.dividend = pick_operand();
		r.divisor  = pick_operand();
		req       <= r;
		req_valid <= (draw_rand() % 100) < valid_pct;
		rsp_ready <= (draw_rand() % 100) < ready_pct;
	endtask

	task automatic run_one_op();
		int                    wait_cnt;
		int                    edges;
		int                    ready_pct;
		bit                    accepted;
		div_bus_pkg::div_rsp_t expected;
		div_bus_pkg::div_rsp_t held;
		// About a third of the operations see rsp_ready held high
		ready_pct = (draw_rand() % 3 == 0) ? 100 : 35;
		accepted  = 1'b0;
		wait_cnt  = 0;
		while (!accepted) begin
			if (wait_cnt == ACCEPT_TIMEOUT) timeout_failure("a request to be accepted");
			@(posedge CLK);
			drive_random_inputs(60, ready_pct);
			@(negedge CLK);
			check_bit("req_ready", 1'b1, req_ready);
			check_bit("rsp_valid", 1'b0, rsp_valid);
			// Stall goes up in the accepting cycle itself
			check_bit("busy", req_valid, busy);
			if (req_valid) begin
				exp_q.push_back(model_div(req));
				accepted = 1'b1;
			end
			wait_cnt++;
		end
		// The next rising edge is the accepting edge and counts as edge 0
		edges = -1;
		do begin
			if (edges == RSP_TIMEOUT) timeout_failure("rsp_valid");
			@(posedge CLK);
			drive_random_inputs(50, ready_pct);
			edges++;
			@(negedge CLK);
			check_bit("busy", 1'b1, busy);
			check_bit("req_ready", 1'b0, req_ready);
		end while (!rsp_valid);
		check_latency("rsp_valid latency", LATENCY, edges);
		expected = exp_q.pop_front();
		check_rsp("rsp", expected, rsp);
		held     = rsp;
		wait_cnt = 0;
		// Under back-pressure the response must stay put until rsp_ready is seen
		while (!rsp_ready) begin
			if (wait_cnt == HANDSHAKE_TIMEOUT) timeout_failure("the response handshake");
			@(posedge CLK);
			drive_random_inputs(50, ready_pct);
			@(negedge CLK);
			check_bit("rsp_valid", 1'b1, rsp_valid);
			check_bit("req_ready", 1'b0, req_ready);
			check_bit("busy", 1'b1, busy);
			check_rsp("rsp", held, rsp);
			wait_cnt++;
		end
	endtask

	initial begin
		CLK       = 1'b0;
		nrst      = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		rsp_ready = 1'b0;
		rng_state = 32'ha6d68e59;
		repeat (8) @(posedge CLK);
		nrst <= 1'b1;
		@(negedge CLK);
		check_bit("req_ready", 1'b1, req_ready);
		check_bit("rsp_valid", 1'b0, rsp_valid);
		check_bit("busy", 1'b0, busy);
		for (int i = 0; i < NUM_OPS; i++) begin
			run_one_op();
		end
		// The last response handshake completes on the next rising edge
		@(posedge CLK);
		req_valid <= 1'b0;
		@(negedge CLK);
		if (rsp_count == NUM_OPS) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("Response handshakes seen: %0d for %0d requests", rsp_count, NUM_OPS);
			stop_on_error();
		end
	end

endmodule

/* list.f */
+incdir+testbench
verilog/div_types_pkg.sv
verilog/div_bus_pkg.sv
verilog/div_operand_prep.sv
verilog/div_radix2_core.sv
verilog/div_result_fix.sv
verilog/div_unit_ctrl.sv
verilog/div_subsystem.sv
testbench/tb_div_subsystem.sv

/* Bender.yml */
package:
  name: div_subsystem

sources:
  - files:
      - verilog/div_types_pkg.sv
      - verilog/div_bus_pkg.sv
      - verilog/div_operand_prep.sv
      - verilog/div_radix2_core.sv
      - verilog/div_result_fix.sv
      - verilog/div_unit_ctrl.sv
      - verilog/div_subsystem.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_div_subsystem.sv
